//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath width in bits
`define CPU_XLEN 32

// Register file size and address width
`define CPU_NREGS 16
`define CPU_REGW 4

// Instruction fields, most significant first:
//   [31:27] opcode
//   [26:23] rc, destination
//   [22:19] ra
//   [18:15] rb
//   [14:0]  imm15, sign extended where used
`define CPU_OPW 5
`define CPU_IMMW 15

`endif

//--- cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [`CPU_OPW-1:0] {
        opAdd  = 5'd0,
        opSub  = 5'd1,
        opAnd  = 5'd2,
        opOr   = 5'd3,
        opAddi = 5'd4,
        opMul  = 5'd5,
        opMfhi = 5'd6,
        opMflo = 5'd7,
        opLd   = 5'd8,
        opSt   = 5'd9,
        opBrz  = 5'd10,
        opJal  = 5'd11,
        opJr   = 5'd12,
        opHalt = 5'd13
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluMul   = 3'd4,
        aluPassB = 3'd5
    } aluOpT;

    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExecute   = 3'd2,
        stMemory    = 3'd3,
        stWriteback = 3'd4,
        stHalted    = 3'd5
    } cpuStateT;

    typedef struct packed {
        opcodeT                opcode;
        logic [`CPU_REGW-1:0]  rc;
        logic [`CPU_REGW-1:0]  ra;
        logic [`CPU_REGW-1:0]  rb;
        logic [`CPU_IMMW-1:0]  imm15;
    } instrT;

    // Datapath enables and selects, one set per cycle
    typedef struct packed {
        logic pcEn;
        logic pcBranch;
        logic pcJumpReg;
        logic pcLink;
        logic rfWrite;
        logic latchAB;
        logic latchZ;
        logic latchHiLo;
        logic bSelImm;
        logic zSelHigh;
        logic zSelStore;
        logic marSelAlu;
        logic marEn;
        logic mdrEn;
        logic wbSelMem;
        logic irEn;
    } ctrlT;

endpackage

//--- ProgramCounter.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module ProgramCounter (
    input  logic                 iClk,
    input  logic                 rstN,
    input  logic                 en,
    input  logic                 branch,
    input  logic                 jumpReg,
    input  logic [`CPU_XLEN-1:0] imm,
    input  logic [`CPU_XLEN-1:0] target,
    output logic [`CPU_XLEN-1:0] pc,
    output logic [`CPU_XLEN-1:0] linkPc
);

    logic [`CPU_XLEN-1:0] offset;
    logic [`CPU_XLEN-1:0] pcPlus4;

    // Immediate counts instructions, pc counts bytes
    assign offset  = {imm[`CPU_XLEN-3:0], 2'b00};
    assign pcPlus4 = pc + `CPU_XLEN'd4;

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            linkPc <= '0;
        end else if (en) begin
            if (jumpReg) begin
                pc <= target;
            end else if (branch) begin
                // Relative to the instruction after the branch
                pc <= linkPc + offset;
            end else begin
                pc     <= pcPlus4;
                linkPc <= pcPlus4;
            end
        end
    end

endmodule

//--- RegFile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module RegFile (
    input  logic                 iClk,
    input  logic                 rstN,
    input  logic                 write,
    input  logic [`CPU_REGW-1:0] addrA,
    input  logic [`CPU_REGW-1:0] addrB,
    input  logic [`CPU_REGW-1:0] addrC,
    input  logic [`CPU_XLEN-1:0] dataC,
    output logic [`CPU_XLEN-1:0] regA,
    output logic [`CPU_XLEN-1:0] regB
);

    // No storage behind register 0
    logic [`CPU_XLEN-1:0] regs [1:`CPU_NREGS-1];

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (addrC != '0)) begin
            regs[addrC] <= dataC;
        end
    end

    // Read ports are combinational
    assign regA = (addrA == '0) ? '0 : regs[addrA];
    assign regB = (addrB == '0) ? '0 : regs[addrB];

endmodule

//--- Alu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module Alu (
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  cpu_pkg::aluOpT       op,
    output logic [`CPU_XLEN-1:0] resultHi,
    output logic [`CPU_XLEN-1:0] resultLo,
    output logic                 zero,
    output logic                 negative
);

    logic [2*`CPU_XLEN-1:0] product;

    // Unsigned full-width product
    assign product = {{`CPU_XLEN{1'b0}}, a} * {{`CPU_XLEN{1'b0}}, b};

    always_comb begin
        resultHi = '0;
        case (op)
            cpu_pkg::aluAdd: begin
                resultLo = a + b;
            end
            cpu_pkg::aluSub: begin
                resultLo = a - b;
            end
            cpu_pkg::aluAnd: begin
                resultLo = a & b;
            end
            cpu_pkg::aluOr: begin
                resultLo = a | b;
            end
            cpu_pkg::aluMul: begin
                resultHi = product[2*`CPU_XLEN-1:`CPU_XLEN];
                resultLo = product[`CPU_XLEN-1:0];
            end
            cpu_pkg::aluPassB: begin
                resultLo = b;
            end
            default: begin
                resultLo = '0;
            end
        endcase
    end

    // Flags look at the low word only
    assign zero     = (resultLo == '0);
    assign negative = resultLo[`CPU_XLEN-1];

endmodule

//--- ControlUnit.sv
`timescale 1ns/1ps

module ControlUnit (
    input  logic            iClk,
    input  logic            rstN,
    input  cpu_pkg::instrT  instr,
    input  logic            aluZero,
    input  logic            memReady,
    output cpu_pkg::ctrlT   ctrl,
    output cpu_pkg::aluOpT  aluOp,
    output logic            memRead,
    output logic            memWrite,
    output logic            halted
);

    cpu_pkg::cpuStateT state;
    cpu_pkg::cpuStateT nextState;
    cpu_pkg::opcodeT   opcode;
    logic              isLoad;
    logic              isStore;
    logic              writesBack;
    logic              takeBranch;

    assign opcode     = instr.opcode;
    assign isLoad     = (opcode == cpu_pkg::opLd);
    assign isStore    = (opcode == cpu_pkg::opSt);
    assign writesBack = opcode inside {cpu_pkg::opAdd, cpu_pkg::opSub, cpu_pkg::opAnd,
                                       cpu_pkg::opOr, cpu_pkg::opAddi, cpu_pkg::opMul,
                                       cpu_pkg::opMfhi, cpu_pkg::opMflo, cpu_pkg::opJal};
    // BRZ tests operand A passed through the ALU
    assign takeBranch = ((opcode == cpu_pkg::opBrz) && aluZero) || (opcode == cpu_pkg::opJal);

    // Reset parks in WRITEBACK, the cleared IR writes only register 0,
    // so the first fetch is raised one clock after release
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            state <= cpu_pkg::stWriteback;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpu_pkg::stFetch: begin
                if (memReady) begin
                    nextState = cpu_pkg::stDecode;
                end
            end
            cpu_pkg::stDecode: begin
                nextState = cpu_pkg::stExecute;
            end
            cpu_pkg::stExecute: begin
                if (isLoad || isStore) begin
                    nextState = cpu_pkg::stMemory;
                end else if (writesBack) begin
                    nextState = cpu_pkg::stWriteback;
                end else if (opcode == cpu_pkg::opHalt) begin
                    nextState = cpu_pkg::stHalted;
                end else begin
                    nextState = cpu_pkg::stFetch;
                end
            end
            cpu_pkg::stMemory: begin
                if (memReady) begin
                    nextState = isLoad ? cpu_pkg::stWriteback : cpu_pkg::stFetch;
                end
            end
            cpu_pkg::stWriteback: begin
                nextState = cpu_pkg::stFetch;
            end
            default: begin
                nextState = cpu_pkg::stHalted;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            cpu_pkg::opSub: aluOp = cpu_pkg::aluSub;
            cpu_pkg::opAnd: aluOp = cpu_pkg::aluAnd;
            cpu_pkg::opOr:  aluOp = cpu_pkg::aluOr;
            cpu_pkg::opMul: aluOp = cpu_pkg::aluMul;
            cpu_pkg::opBrz: aluOp = cpu_pkg::aluPassB;
            cpu_pkg::opJal: aluOp = cpu_pkg::aluPassB;
            // ADD, ADDI and LD/ST address generation
            default:        aluOp = cpu_pkg::aluAdd;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            cpu_pkg::stFetch: begin
                ctrl.irEn = memReady;
                ctrl.pcEn = memReady;
            end
            cpu_pkg::stDecode: begin
                ctrl.latchAB = 1'b1;
            end
            cpu_pkg::stExecute: begin
                ctrl.latchZ    = 1'b1;
                ctrl.latchHiLo = (opcode == cpu_pkg::opMul);
                ctrl.bSelImm   = opcode inside {cpu_pkg::opAddi, cpu_pkg::opLd, cpu_pkg::opSt};
                ctrl.pcLink    = (opcode == cpu_pkg::opJal);
                ctrl.marEn     = isLoad || isStore;
                ctrl.mdrEn     = isStore;
                ctrl.pcJumpReg = (opcode == cpu_pkg::opJr);
                ctrl.pcBranch  = takeBranch;
                ctrl.pcEn      = takeBranch || (opcode == cpu_pkg::opJr);
            end
            cpu_pkg::stMemory: begin
                ctrl.marSelAlu = 1'b1;
                ctrl.mdrEn     = isLoad && memReady;
                ctrl.wbSelMem  = isLoad;
            end
            cpu_pkg::stWriteback: begin
                ctrl.rfWrite   = 1'b1;
                ctrl.wbSelMem  = isLoad;
                ctrl.zSelStore = opcode inside {cpu_pkg::opMfhi, cpu_pkg::opMflo};
                ctrl.zSelHigh  = (opcode == cpu_pkg::opMfhi);
            end
            default: begin
            end
        endcase
    end

    assign memRead  = (state == cpu_pkg::stFetch) || ((state == cpu_pkg::stMemory) && isLoad);
    assign memWrite = (state == cpu_pkg::stMemory) && isStore;
    assign halted   = (state == cpu_pkg::stHalted);

endmodule

//--- Processor.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module Processor (
    input  logic                 iClk,
    input  logic                 rstN,
    output logic [`CPU_XLEN-1:0] memAddr,
    output logic [`CPU_XLEN-1:0] memWriteData,
    input  logic [`CPU_XLEN-1:0] memReadData,
    input  logic                 memReady,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 halted
);

    cpu_pkg::ctrlT        ctrl;
    cpu_pkg::aluOpT       aluOp;
    cpu_pkg::instrT       ir;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] linkPc;
    logic [`CPU_XLEN-1:0] immExt;
    logic [`CPU_REGW-1:0] rfAddrB;
    logic [`CPU_XLEN-1:0] regA;
    logic [`CPU_XLEN-1:0] regB;
    logic [`CPU_XLEN-1:0] latchA;
    logic [`CPU_XLEN-1:0] latchB;
    logic [`CPU_XLEN-1:0] aluB;
    logic [`CPU_XLEN-1:0] aluHi;
    logic [`CPU_XLEN-1:0] aluLo;
    logic                 aluZero;
    logic [`CPU_XLEN-1:0] zHi;
    logic [`CPU_XLEN-1:0] zLo;
    logic [`CPU_XLEN-1:0] storeHi;
    logic [`CPU_XLEN-1:0] storeLo;
    logic [`CPU_XLEN-1:0] zOut;
    logic [`CPU_XLEN-1:0] wbData;
    logic [`CPU_XLEN-1:0] mar;
    logic [`CPU_XLEN-1:0] mdr;

    assign immExt = {{(`CPU_XLEN-`CPU_IMMW){ir.imm15[`CPU_IMMW-1]}}, ir.imm15};
    // BRZ reads its tested register on port B so PASSB can show it on the zero flag
    assign rfAddrB = (ir.opcode == cpu_pkg::opBrz) ? ir.ra : ir.rb;

    // Instruction register feeds the decoder
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            ir <= '0;
        end else if (ctrl.irEn) begin
            ir <= memReadData;
        end
    end

    always_ff @(posedge iClk) begin
        if (ctrl.latchAB) begin
            latchA <= regA;
            latchB <= regB;
        end
        if (ctrl.latchZ) begin
            zHi <= aluHi;
            zLo <= aluLo;
        end
        // Hi/lo storage persists until the next MUL
        if (ctrl.latchHiLo) begin
            storeHi <= aluHi;
            storeLo <= aluLo;
        end
        if (ctrl.marEn) begin
            mar <= aluLo;
        end
        // Store data from B, load data from memory
        if (ctrl.mdrEn) begin
            mdr <= ctrl.wbSelMem ? memReadData : latchB;
        end
    end

    // JAL passes the link address through the ALU
    assign aluB = ctrl.pcLink ? linkPc : (ctrl.bSelImm ? immExt : latchB);

    assign zOut   = ctrl.zSelStore ? (ctrl.zSelHigh ? storeHi : storeLo)
                                   : (ctrl.zSelHigh ? zHi : zLo);
    assign wbData = ctrl.wbSelMem ? mdr : zOut;

    // Fetch uses the PC register, data access the MAR
    assign memAddr      = ctrl.marSelAlu ? mar : pc;
    assign memWriteData = mdr;

    ProgramCounter i_ProgramCounter (
        .iClk    (iClk),
        .rstN    (rstN),
        .en      (ctrl.pcEn),
        .branch  (ctrl.pcBranch),
        .jumpReg (ctrl.pcJumpReg),
        .imm     (immExt),
        .target  (latchA),
        .pc      (pc),
        .linkPc  (linkPc)
    );

    RegFile i_RegFile (
        .iClk  (iClk),
        .rstN  (rstN),
        .write (ctrl.rfWrite),
        .addrA (ir.ra),
        .addrB (rfAddrB),
        .addrC (ir.rc),
        .dataC (wbData),
        .regA  (regA),
        .regB  (regB)
    );

    Alu i_Alu (
        .a        (latchA),
        .b        (aluB),
        .op       (aluOp),
        .resultHi (aluHi),
        .resultLo (aluLo),
        .zero     (aluZero),
        .negative ()
    );

    ControlUnit i_ControlUnit (
        .iClk     (iClk),
        .rstN     (rstN),
        .instr    (ir),
        .aluZero  (aluZero),
        .memReady (memReady),
        .ctrl     (ctrl),
        .aluOp    (aluOp),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted)
    );

endmodule

//--- Processor_properties.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module Processor_properties (
    input logic                 iClk,
    input logic                 rstN,
    input logic                 memRead,
    input logic                 memWrite,
    input logic                 memReady,
    input logic                 halted,
    input logic [`CPU_XLEN-1:0] memAddr
);

    // One access direction at a time
    property exclusiveAccess;
        @(posedge iClk) disable iff (!rstN) !(memRead && memWrite);
    endproperty

    property addrHeldWhileWaiting;
        @(posedge iClk) disable iff (!rstN)
            ((memRead || memWrite) && !memReady) |=> $stable(memAddr);
    endproperty

    property quietWhenHalted;
        @(posedge iClk) disable iff (!rstN) halted |-> (!memRead && !memWrite);
    endproperty

    exclusiveCheck: assert property (exclusiveAccess)
        else $error("memRead and memWrite high together");
    addrHeldCheck: assert property (addrHeldWhileWaiting)
        else $error("memAddr changed before memReady");
    haltedCheck: assert property (quietWhenHalted)
        else $error("memory request while halted");

endmodule

bind Processor Processor_properties i_Processor_properties (
    .iClk     (iClk),
    .rstN     (rstN),
    .memRead  (memRead),
    .memWrite (memWrite),
    .memReady (memReady),
    .halted   (halted),
    .memAddr  (memAddr)
);

//--- Processor_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module Processor_tb;

    logic                 iClk;
    logic                 rstN;
    logic [`CPU_XLEN-1:0] memAddr;
    logic [`CPU_XLEN-1:0] memWriteData;
    logic [`CPU_XLEN-1:0] memReadData;
    logic                 memReady;
    logic                 memRead;
    logic                 memWrite;
    logic                 halted;

    // Word-addressed memory, byte address bits [9:2]
    logic [`CPU_XLEN-1:0] mem [0:255];
    logic [`CPU_XLEN-1:0] refMem [0:255];
    logic [`CPU_XLEN-1:0] expAddr [$];
    logic [`CPU_XLEN-1:0] expData [$];
    logic [31:0]          lcgState;
    logic [1:0]           delayLeft;
    logic                 busy;
    logic                 waiting;
    logic                 sawHalt;
    logic                 refHalted;
    logic [`CPU_XLEN-1:0] heldAddr;
    int                   progLen;
    int                   storeCount;
    int                   cycleCount;
    int                   timeoutLimit;

    Processor i_Processor (
        .iClk         (iClk),
        .rstN         (rstN),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memReadData  (memReadData),
        .memReady     (memReady),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .halted       (halted)
    );

    initial begin
        iClk = 1'b0;
        forever #2 iClk = ~iClk;
    end

    task automatic stopWithFailure();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic checkWord(input string name, input logic [`CPU_XLEN-1:0] expected,
                             input logic [`CPU_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            stopWithFailure();
        end
    endtask

    // LCG step, returns a ready delay of 0 to 3 cycles
    function automatic logic [1:0] drawDelay();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[17:16];
    endfunction

    task automatic placeInstr(input cpu_pkg::opcodeT op, input int rc, input int ra,
                              input int rb, input int imm);
        cpu_pkg::instrT ins;
        ins.opcode = op;
        ins.rc     = rc[`CPU_REGW-1:0];
        ins.ra     = ra[`CPU_REGW-1:0];
        ins.rb     = rb[`CPU_REGW-1:0];
        ins.imm15  = imm[`CPU_IMMW-1:0];
        mem[progLen[7:0]] = ins;
        progLen++;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = {16'hdead, i[15:0]};
        end
        mem[8'd64] = 32'h1234_5678;
        mem[8'd65] = 32'hffff_fff0;
        progLen = 0;
        placeInstr(cpu_pkg::opAddi, 1, 0, 0, 100);
        placeInstr(cpu_pkg::opAddi, 2, 0, 0, -7);
        placeInstr(cpu_pkg::opAdd, 3, 1, 2, 0);
        placeInstr(cpu_pkg::opSt, 0, 0, 3, 'h200);
        placeInstr(cpu_pkg::opSub, 4, 1, 2, 0);
        placeInstr(cpu_pkg::opSt, 0, 0, 4, 'h204);
        placeInstr(cpu_pkg::opAnd, 5, 1, 2, 0);
        placeInstr(cpu_pkg::opSt, 0, 0, 5, 'h208);
        placeInstr(cpu_pkg::opOr, 6, 1, 2, 0);
        placeInstr(cpu_pkg::opSt, 0, 0, 6, 'h20c);
        // Product wider than 32 bits
        placeInstr(cpu_pkg::opLd, 7, 0, 0, 'h100);
        placeInstr(cpu_pkg::opLd, 8, 0, 0, 'h104);
        placeInstr(cpu_pkg::opMul, 9, 7, 8, 0);
        placeInstr(cpu_pkg::opMfhi, 10, 0, 0, 0);
        placeInstr(cpu_pkg::opMflo, 11, 0, 0, 0);
        placeInstr(cpu_pkg::opSt, 0, 0, 10, 'h210);
        placeInstr(cpu_pkg::opSt, 0, 0, 11, 'h214);
        placeInstr(cpu_pkg::opSt, 0, 0, 9, 'h218);
        placeInstr(cpu_pkg::opSt, 0, 0, 7, 'h21c);
        // Read back a stored word, store it through a nonzero base
        placeInstr(cpu_pkg::opLd, 14, 0, 0, 'h200);
        placeInstr(cpu_pkg::opSt, 0, 1, 14, 'h1bc);
        // Taken branch skips one store, untaken one does not
        placeInstr(cpu_pkg::opBrz, 0, 0, 0, 1);
        placeInstr(cpu_pkg::opSt, 0, 0, 1, 'h224);
        placeInstr(cpu_pkg::opBrz, 0, 1, 0, 1);
        placeInstr(cpu_pkg::opSt, 0, 0, 1, 'h228);
        // Countdown loop with a backward branch
        placeInstr(cpu_pkg::opAddi, 13, 0, 0, 3);
        placeInstr(cpu_pkg::opAddi, 13, 13, 0, -1);
        placeInstr(cpu_pkg::opSt, 0, 0, 13, 'h22c);
        placeInstr(cpu_pkg::opBrz, 0, 13, 0, 1);
        placeInstr(cpu_pkg::opBrz, 0, 0, 0, -4);
        // Call and return
        placeInstr(cpu_pkg::opJal, 12, 0, 0, 2);
        placeInstr(cpu_pkg::opSt, 0, 0, 12, 'h230);
        placeInstr(cpu_pkg::opHalt, 0, 0, 0, 0);
        placeInstr(cpu_pkg::opSt, 0, 0, 12, 'h234);
        placeInstr(cpu_pkg::opJr, 0, 12, 0, 0);
    endtask

    // Instruction-level model, fills the expected store queues
    function automatic int runReference();
        logic [`CPU_XLEN-1:0]   regs [0:`CPU_NREGS-1];
        logic [`CPU_XLEN-1:0]   pc;
        logic [`CPU_XLEN-1:0]   nextPc;
        logic [`CPU_XLEN-1:0]   immExt;
        logic [`CPU_XLEN-1:0]   a;
        logic [`CPU_XLEN-1:0]   b;
        logic [`CPU_XLEN-1:0]   addr;
        logic [`CPU_XLEN-1:0]   result;
        logic [`CPU_XLEN-1:0]   hi;
        logic [`CPU_XLEN-1:0]   lo;
        logic [2*`CPU_XLEN-1:0] product;
        logic                   writeRc;
        cpu_pkg::instrT         ins;
        int                     count;
        for (int i = 0; i < `CPU_NREGS; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        hi = '0;
        lo = '0;
        count = 0;
        refHalted = 1'b0;
        while (!refHalted && count < 1000) begin
            ins = refMem[pc[9:2]];
            a = regs[ins.ra];
            b = regs[ins.rb];
            immExt = {{(`CPU_XLEN-`CPU_IMMW){ins.imm15[`CPU_IMMW-1]}}, ins.imm15};
            addr = a + immExt;
            nextPc = pc + 32'd4;
            writeRc = 1'b1;
            result = '0;
            count++;
            case (ins.opcode)
                cpu_pkg::opAdd:  result = a + b;
                cpu_pkg::opSub:  result = a - b;
                cpu_pkg::opAnd:  result = a & b;
                cpu_pkg::opOr:   result = a | b;
                cpu_pkg::opAddi: result = a + immExt;
                cpu_pkg::opMul: begin
                    product = {{`CPU_XLEN{1'b0}}, a} * {{`CPU_XLEN{1'b0}}, b};
                    hi = product[2*`CPU_XLEN-1:`CPU_XLEN];
                    lo = product[`CPU_XLEN-1:0];
                    result = lo;
                end
                cpu_pkg::opMfhi: result = hi;
                cpu_pkg::opMflo: result = lo;
                cpu_pkg::opLd:   result = refMem[addr[9:2]];
                cpu_pkg::opSt: begin
                    writeRc = 1'b0;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    refMem[addr[9:2]] = b;
                end
                cpu_pkg::opBrz: begin
                    writeRc = 1'b0;
                    if (a == '0) begin
                        nextPc = nextPc + (immExt << 2);
                    end
                end
                cpu_pkg::opJal: begin
                    result = nextPc;
                    nextPc = nextPc + (immExt << 2);
                end
                cpu_pkg::opJr: begin
                    writeRc = 1'b0;
                    nextPc = a;
                end
                cpu_pkg::opHalt: begin
                    writeRc = 1'b0;
                    refHalted = 1'b1;
                end
                default: writeRc = 1'b0;
            endcase
            if (writeRc && ins.rc != '0) begin
                regs[ins.rc] = result;
            end
            pc = nextPc;
        end
        return count;
    endfunction

    // Memory responder, ready after a random delay
    always @(posedge iClk) begin
        #1;
        if (!rstN) begin
            memReady = 1'b0;
            busy = 1'b0;
        end else begin
            if (memReady) begin
                memReady = 1'b0;
                busy = 1'b0;
            end
            if (memRead || memWrite) begin
                if (!busy) begin
                    busy = 1'b1;
                    delayLeft = drawDelay();
                end
                if (delayLeft == 2'd0) begin
                    memReady = 1'b1;
                    if (memRead) begin
                        memReadData = mem[memAddr[9:2]];
                    end
                end else begin
                    delayLeft = delayLeft - 2'd1;
                end
            end
        end
    end

    // Compares stores and watches the bus rules mid-cycle
    always @(negedge iClk) begin
        if (rstN) begin
            if (memRead && memWrite) begin
                $display("memRead and memWrite are both high at address 0x%08h", memAddr);
                stopWithFailure();
            end
            if (waiting) begin
                checkFlag("request held until ready", 1'b1, memRead || memWrite);
                checkWord("address held until ready", heldAddr, memAddr);
            end
            if (halted) begin
                sawHalt = 1'b1;
                checkFlag("memRead while halted", 1'b0, memRead);
                checkFlag("memWrite while halted", 1'b0, memWrite);
            end else if (sawHalt) begin
                $display("halted went low again after HALT");
                stopWithFailure();
            end
            if (memWrite && memReady) begin
                if (expAddr.size() == 0) begin
                    $display("Store to 0x%08h is not in the reference store list", memAddr);
                    stopWithFailure();
                end else begin
                    checkWord($sformatf("store %0d address", storeCount),
                              expAddr.pop_front(), memAddr);
                    checkWord($sformatf("store %0d data", storeCount),
                              expData.pop_front(), memWriteData);
                    mem[memAddr[9:2]] = memWriteData;
                    storeCount++;
                end
            end
            waiting = (memRead || memWrite) && !memReady;
            heldAddr = memAddr;
        end
    end

    always @(posedge iClk) begin
        if (rstN) begin
            cycleCount++;
            if (cycleCount > timeoutLimit) begin
                $display("Timeout after %0d cycles without reaching HALT", timeoutLimit);
                stopWithFailure();
            end
        end
    end

    initial begin
        rstN = 1'b0;
        memReady = 1'b0;
        memReadData = '0;
        lcgState = 32'hdc82;
        delayLeft = 2'd0;
        busy = 1'b0;
        waiting = 1'b0;
        sawHalt = 1'b0;
        heldAddr = '0;
        storeCount = 0;
        cycleCount = 0;
        loadProgram();
        for (int i = 0; i < 256; i++) begin
            refMem[i[7:0]] = mem[i[7:0]];
        end
        // Executed instructions x 4 accesses x 8 cycles
        timeoutLimit = runReference() * 4 * 8;
        if (!refHalted) begin
            $display("Reference model never reached HALT");
            stopWithFailure();
        end
        repeat (3) @(posedge iClk);
        @(negedge iClk);
        checkFlag("reset memRead", 1'b0, memRead);
        checkFlag("reset memWrite", 1'b0, memWrite);
        checkFlag("reset halted", 1'b0, halted);
        checkWord("reset memAddr", '0, memAddr);
        @(posedge iClk);
        #1;
        rstN = 1'b1;
        // First fetch starts at the clock edge after release
        @(posedge iClk);
        @(negedge iClk);
        checkFlag("first fetch memRead", 1'b1, memRead);
        checkWord("first fetch memAddr", '0, memAddr);
        while (!halted) @(negedge iClk);
        // Bus must stay quiet after HALT
        repeat (12) @(negedge iClk);
        if (expAddr.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("%0d reference stores never appeared on the bus", expAddr.size());
            stopWithFailure();
        end
    end

endmodule

//--- files.f
+incdir+.
cpu_pkg.sv
ProgramCounter.sv
RegFile.sv
Alu.sv
ControlUnit.sv
Processor.sv
Processor_properties.sv
Processor_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= Processor_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run did not finish, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
